//--- dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = WORD_W / 8;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_BANKS  = 8;
    localparam int NUM_SETS   = 64;
    localparam int BANK_W     = 3;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = 21;

    // field positions inside an address
    localparam int BANK_LSB  = 2;
    localparam int INDEX_LSB = BANK_LSB + BANK_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [WORD_W-1:0]     word_t;
    // bank 0 sits in the low word
    typedef word_t [NUM_BANKS-1:0] line_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [BANK_W-1:0]     bank_t;
    typedef logic [WORD_BYTES-1:0] byte_en_t;
    typedef logic [NUM_BANKS-1:0]  bank_mask_t;

    // processor request
    typedef struct packed {
        logic              en;
        byte_en_t          wen;
        logic [ADDR_W-1:0] vaddr;
        logic [ADDR_W-1:0] paddr;
        word_t             wdata;
        logic              cached;
    } req_t;

    // feedback from stage two, old_* is last cycle's request
    typedef struct packed {
        logic              rreq;
        logic              wreq;
        logic              hit0;
        logic              hit1;
        logic              write_miss;
        logic              refilling;
        word_t             hit_wdata;
        logic [ADDR_W-1:0] old_vaddr;
        logic [ADDR_W-1:0] old_paddr;
        byte_en_t          old_wen;
        word_t             old_data;
    } s2_fb_t;

    // registered stage one output
    typedef struct packed {
        logic [ADDR_W-1:0] vaddr;
        logic [ADDR_W-1:0] paddr;
        logic              cached;
        byte_en_t          wen;
        logic              valid0;
        logic              valid1;
        logic              dirty0;
        logic              dirty1;
        bank_mask_t        colli0;
        bank_mask_t        colli1;
        word_t             colli_wdata;
        logic              cache_rreq;
        logic              cache_wreq;
        logic              uc_rreq;
        logic              uc_wreq;
    } s1_out_t;

    //////////////////////////////
    // address field helpers
    //////////////////////////////

    function automatic index_t index_of(logic [ADDR_W-1:0] addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic bank_t bank_of(logic [ADDR_W-1:0] addr);
        return addr[BANK_LSB +: BANK_W];
    endfunction

    function automatic tag_t tag_of(logic [ADDR_W-1:0] addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

endpackage

//--- dcache_sdp_ram.sv
module dcache_sdp_ram #(
    parameter type entry_t = dcache_pkg::word_t
) (
    input  logic               clk,
    input  logic               we_i,
    input  dcache_pkg::index_t waddr_i,
    input  entry_t             wdata_i,
    input  logic               re_i,
    input  dcache_pkg::index_t raddr_i,
    output entry_t             rdata_o
);

    entry_t mem [dcache_pkg::NUM_SETS];

    // write port, driven from the old index
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read port, output holds while re_i is low
    // same-address write in the same cycle returns the old entry
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_waddr_known: assert property (
        @(posedge clk) we_i |-> !$isunknown(waddr_i)
    ) else $error("sdp_ram: write address unknown while writing");

    a_raddr_known: assert property (
        @(posedge clk) re_i |-> !$isunknown(raddr_i)
    ) else $error("sdp_ram: read address unknown while reading");

endmodule

//--- dcache_line_state.sv
module dcache_line_state (
    input  logic                            clk,
    input  logic                            rst_n,
    input  dcache_pkg::index_t              rd_index_i,
    input  dcache_pkg::s2_fb_t              s2_fb_i,
    input  logic                            rend_i,
    output logic [dcache_pkg::NUM_WAYS-1:0] valid_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] dirty_o,
    output logic                            lru_way_o,
    output logic                            merge_pending_o
);

    logic [dcache_pkg::NUM_SETS-1:0][dcache_pkg::NUM_WAYS-1:0] valid_q;
    logic [dcache_pkg::NUM_SETS-1:0][dcache_pkg::NUM_WAYS-1:0] dirty_q;
    logic [dcache_pkg::NUM_SETS-1:0]                           lru_q;
    logic                                                      merge_pending_q;

    dcache_pkg::index_t old_index;
    logic               hit_any;
    logic               refill;

    assign old_index = dcache_pkg::index_of(s2_fb_i.old_vaddr);

    // hit only counts when stage two holds a cached request
    assign hit_any = (s2_fb_i.hit0 | s2_fb_i.hit1) & (s2_fb_i.rreq | s2_fb_i.wreq);
    assign refill  = rend_i & s2_fb_i.refilling;

    // lru bit names the way to replace next
    assign lru_way_o       = lru_q[old_index];
    assign merge_pending_o = merge_pending_q;

    // state at the index being read this cycle
    assign valid_o = valid_q[rd_index_i];
    assign dirty_o = dirty_q[rd_index_i];

    //////////////////////////////
    // lru
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (hit_any) begin
            // point away from the way that hit
            lru_q[old_index] <= s2_fb_i.hit0;
        end else if (refill) begin
            lru_q[old_index] <= ~lru_way_o;
        end
    end

    //////////////////////////////
    // valid and dirty
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (refill) begin
            valid_q[old_index][lru_way_o] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dirty_q <= '0;
        end else if (refill) begin
            // refilled line is dirty only if a write miss got merged in
            dirty_q[old_index][lru_way_o] <= merge_pending_q;
        end else if (s2_fb_i.wreq && s2_fb_i.hit0) begin
            dirty_q[old_index][0] <= 1'b1;
        end else if (s2_fb_i.wreq && s2_fb_i.hit1) begin
            dirty_q[old_index][1] <= 1'b1;
        end
    end

    // write miss waiting for its refill line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            merge_pending_q <= 1'b0;
        end else if (s2_fb_i.write_miss) begin
            merge_pending_q <= 1'b1;
        end else if (rend_i) begin
            merge_pending_q <= 1'b0;
        end
    end

    a_one_hit_way: assert property (
        @(posedge clk) disable iff (!rst_n) !(s2_fb_i.hit0 && s2_fb_i.hit1)
    ) else $error("line_state: stage two reports a hit in both ways");

endmodule

//--- dcache_data_wr_arb.sv
module dcache_data_wr_arb (
    input  dcache_pkg::s2_fb_t              s2_fb_i,
    input  logic                            rend_i,
    input  dcache_pkg::line_t               line_rdata_i,
    input  logic                            lru_way_i,
    input  logic                            merge_pending_i,
    output dcache_pkg::bank_mask_t          we_way0_o,
    output dcache_pkg::bank_mask_t          we_way1_o,
    output dcache_pkg::line_t               wdata_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] tag_we_o,
    output dcache_pkg::bank_mask_t          hit_wmask0_o,
    output dcache_pkg::bank_mask_t          hit_wmask1_o
);

    dcache_pkg::bank_t      old_bank;
    dcache_pkg::bank_mask_t old_bank_sel;
    dcache_pkg::line_t      merged_line;
    logic                   refill;
    logic                   hit_wr;
    logic                   refill_way0;
    logic                   refill_way1;

    assign old_bank     = dcache_pkg::bank_of(s2_fb_i.old_vaddr);
    assign old_bank_sel = dcache_pkg::bank_mask_t'(1) << old_bank;

    assign refill = rend_i & s2_fb_i.refilling;
    assign hit_wr = s2_fb_i.wreq & (s2_fb_i.hit0 | s2_fb_i.hit1);

    // refill goes to the lru way
    assign refill_way0 = refill & ~lru_way_i;
    assign refill_way1 = refill & lru_way_i;

    //////////////////////////////
    // hit write peer
    //////////////////////////////

    // one bank of the hit way
    assign hit_wmask0_o = (s2_fb_i.wreq && s2_fb_i.hit0) ? old_bank_sel : '0;
    assign hit_wmask1_o = (s2_fb_i.wreq && s2_fb_i.hit1) ? old_bank_sel : '0;

    //////////////////////////////
    // refill peer
    //////////////////////////////

    // pending store bytes override the memory line at the old bank
    always_comb begin
        merged_line = line_rdata_i;
        if (merge_pending_i) begin
            for (int k = 0; k < dcache_pkg::WORD_BYTES; k++) begin
                if (s2_fb_i.old_wen[k]) begin
                    merged_line[old_bank][8*k +: 8] = s2_fb_i.old_data[8*k +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // port select
    //////////////////////////////

    // refill owns every bank when active
    assign we_way0_o = refill ? {dcache_pkg::NUM_BANKS{refill_way0}} : hit_wmask0_o;
    assign we_way1_o = refill ? {dcache_pkg::NUM_BANKS{refill_way1}} : hit_wmask1_o;

    // hit data is the same word on all banks, the enables pick one
    assign wdata_o = refill ? merged_line : {dcache_pkg::NUM_BANKS{s2_fb_i.hit_wdata}};

    assign tag_we_o = {refill_way1, refill_way0};

    // stage two must not write while its line is in flight
    always_comb begin
        a_no_overlap: assert final (!(refill && hit_wr))
            else $error("data_wr_arb: refill and hit write in the same cycle");
    end

endmodule

//--- dcache_s1_stage.sv
module dcache_s1_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  dcache_pkg::req_t                req_i,
    input  logic                            stall_i,
    input  dcache_pkg::s2_fb_t              s2_fb_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] valid_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] dirty_i,
    input  dcache_pkg::bank_mask_t          hit_wmask0_i,
    input  dcache_pkg::bank_mask_t          hit_wmask1_i,
    output dcache_pkg::s1_out_t             s1_o
);

    dcache_pkg::s1_out_t s1_d;
    dcache_pkg::s1_out_t s1_q;
    logic                is_write;
    logic                same_index;

    assign is_write = |req_i.wen;

    // read and hit write on the same set this cycle
    assign same_index = dcache_pkg::index_of(req_i.vaddr)
                        == dcache_pkg::index_of(s2_fb_i.old_vaddr);

    //////////////////////////////
    // next stage contents
    //////////////////////////////

    always_comb begin
        s1_d.vaddr  = req_i.vaddr;
        s1_d.paddr  = req_i.paddr;
        s1_d.cached = req_i.cached;
        s1_d.wen    = req_i.wen;

        s1_d.valid0 = valid_i[0];
        s1_d.valid1 = valid_i[1];
        s1_d.dirty0 = dirty_i[0];
        s1_d.dirty1 = dirty_i[1];

        // hit masks already carry the old bank, so the ram word there is stale
        s1_d.colli0      = same_index ? hit_wmask0_i : '0;
        s1_d.colli1      = same_index ? hit_wmask1_i : '0;
        s1_d.colli_wdata = s2_fb_i.hit_wdata;

        // request kind
        s1_d.cache_rreq = req_i.en & req_i.cached & ~is_write;
        s1_d.cache_wreq = req_i.en & req_i.cached & is_write;
        s1_d.uc_rreq    = req_i.en & ~req_i.cached & ~is_write;
        s1_d.uc_wreq    = req_i.en & ~req_i.cached & is_write;
    end

    //////////////////////////////
    // stage register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_q <= '0;
        end else if (!stall_i) begin
            s1_q <= s1_d;
        end
    end

    assign s1_o = s1_q;

    // the kind decode gives one flag only when cached and wen are known
    a_req_kind_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!stall_i && req_i.en) |-> !$isunknown({req_i.cached, req_i.wen})
    ) else $error("s1_stage: request kind unknown while capturing a request");

endmodule

//--- dcache_s1_top.sv
module dcache_s1_top (
    input  logic                clk,
    input  logic                rst_n,

    // processor side
    input  dcache_pkg::req_t    req_i,
    input  logic                stall_i,

    // stage two feedback
    input  dcache_pkg::s2_fb_t  s2_fb_i,

    // memory return, line valid with the pulse
    input  logic                rend_i,
    input  dcache_pkg::line_t   line_rdata_i,

    // to stage two
    output dcache_pkg::s1_out_t s1_o,
    output dcache_pkg::tag_t    tag0_o,
    output dcache_pkg::tag_t    tag1_o,
    output dcache_pkg::word_t   word0_o,
    output dcache_pkg::word_t   word1_o,
    output logic                lru_o,
    output dcache_pkg::line_t   victim_line_o
);

    dcache_pkg::index_t rd_index;
    dcache_pkg::index_t wr_index;
    dcache_pkg::bank_t  old_bank;
    dcache_pkg::tag_t   refill_tag;
    logic               rd_en;

    logic [dcache_pkg::NUM_WAYS-1:0] valid;
    logic [dcache_pkg::NUM_WAYS-1:0] dirty;
    logic                            lru_way;
    logic                            merge_pending;

    dcache_pkg::bank_mask_t          we_way0;
    dcache_pkg::bank_mask_t          we_way1;
    dcache_pkg::bank_mask_t          hit_wmask0;
    dcache_pkg::bank_mask_t          hit_wmask1;
    dcache_pkg::line_t               wdata;
    logic [dcache_pkg::NUM_WAYS-1:0] tag_we;

    dcache_pkg::bank_mask_t [dcache_pkg::NUM_WAYS-1:0] data_we;
    dcache_pkg::tag_t       [dcache_pkg::NUM_WAYS-1:0] tag_rd;
    dcache_pkg::line_t      [dcache_pkg::NUM_WAYS-1:0] way_line;

    // read at the new virtual index, write at the old one
    assign rd_index   = dcache_pkg::index_of(req_i.vaddr);
    assign wr_index   = dcache_pkg::index_of(s2_fb_i.old_vaddr);
    assign old_bank   = dcache_pkg::bank_of(s2_fb_i.old_vaddr);
    assign refill_tag = dcache_pkg::tag_of(s2_fb_i.old_paddr);

    // rams hold their output during a stall
    assign rd_en = ~stall_i;

    assign data_we[0] = we_way0;
    assign data_we[1] = we_way1;

    //////////////////////////////
    // control
    //////////////////////////////

    dcache_line_state u_line_state (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_index_i      (rd_index),
        .s2_fb_i         (s2_fb_i),
        .rend_i          (rend_i),
        .valid_o         (valid),
        .dirty_o         (dirty),
        .lru_way_o       (lru_way),
        .merge_pending_o (merge_pending)
    );

    dcache_data_wr_arb u_data_wr_arb (
        .s2_fb_i         (s2_fb_i),
        .rend_i          (rend_i),
        .line_rdata_i    (line_rdata_i),
        .lru_way_i       (lru_way),
        .merge_pending_i (merge_pending),
        .we_way0_o       (we_way0),
        .we_way1_o       (we_way1),
        .wdata_o         (wdata),
        .tag_we_o        (tag_we),
        .hit_wmask0_o    (hit_wmask0),
        .hit_wmask1_o    (hit_wmask1)
    );

    dcache_s1_stage u_s1_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .stall_i      (stall_i),
        .s2_fb_i      (s2_fb_i),
        .valid_i      (valid),
        .dirty_i      (dirty),
        .hit_wmask0_i (hit_wmask0),
        .hit_wmask1_i (hit_wmask1),
        .s1_o         (s1_o)
    );

    //////////////////////////////
    // tag and data rams
    //////////////////////////////

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        dcache_sdp_ram #(
            .entry_t (dcache_pkg::tag_t)
        ) u_tag_ram (
            .clk     (clk),
            .we_i    (tag_we[w]),
            .waddr_i (wr_index),
            .wdata_i (refill_tag),
            .re_i    (rd_en),
            .raddr_i (rd_index),
            .rdata_o (tag_rd[w])
        );

        // one ram per bank
        for (genvar b = 0; b < dcache_pkg::NUM_BANKS; b++) begin : g_bank
            dcache_sdp_ram #(
                .entry_t (dcache_pkg::word_t)
            ) u_data_ram (
                .clk     (clk),
                .we_i    (data_we[w][b]),
                .waddr_i (wr_index),
                .wdata_i (wdata[b]),
                .re_i    (rd_en),
                .raddr_i (rd_index),
                .rdata_o (way_line[w][b])
            );
        end
    end

    assign tag0_o = tag_rd[0];
    assign tag1_o = tag_rd[1];

    // word of the request now in s1_o
    assign word0_o = way_line[0][old_bank];
    assign word1_o = way_line[1][old_bank];

    // line to write back if the lru way gets replaced
    assign victim_line_o = way_line[lru_way];
    assign lru_o         = lru_way;

endmodule

//--- tb_dcache_s1.sv
module tb_dcache_s1;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk;
    logic                rst_n;
    dcache_pkg::req_t    req_i;
    logic                stall_i;
    dcache_pkg::s2_fb_t  s2_fb_i;
    logic                rend_i;
    dcache_pkg::line_t   line_rdata_i;
    dcache_pkg::s1_out_t s1_o;
    dcache_pkg::tag_t    tag0_o;
    dcache_pkg::tag_t    tag1_o;
    dcache_pkg::word_t   word0_o;
    dcache_pkg::word_t   word1_o;
    logic                lru_o;
    dcache_pkg::line_t   victim_line_o;

    // scoreboard
    logic              sb_valid [dcache_pkg::NUM_SETS][2];
    logic              sb_dirty [dcache_pkg::NUM_SETS][2];
    logic              sb_lru   [dcache_pkg::NUM_SETS];
    dcache_pkg::tag_t  sb_tag   [dcache_pkg::NUM_SETS][2];
    dcache_pkg::line_t sb_line  [dcache_pkg::NUM_SETS][2];
    logic              sb_pending;

    // expected values and their check enables
    logic [3:0]             exp_flags;
    logic [31:0]            exp_vaddr;
    logic [31:0]            exp_paddr;
    logic                   exp_cached;
    dcache_pkg::byte_en_t   exp_wen;
    logic [3:0]             exp_vd;
    dcache_pkg::tag_t       exp_tag0;
    dcache_pkg::tag_t       exp_tag1;
    dcache_pkg::word_t      exp_word0;
    dcache_pkg::word_t      exp_word1;
    logic                   exp_lru;
    dcache_pkg::line_t      exp_victim;
    dcache_pkg::bank_mask_t exp_colli0;
    dcache_pkg::bank_mask_t exp_colli1;
    dcache_pkg::word_t      exp_colli_wdata;
    logic                   chk_flags;
    logic                   chk_state;
    logic                   chk_lru;
    logic                   chk_colli;
    logic                   chk_victim;
    logic [1:0]             chk_tag;
    logic [1:0]             chk_word;

    int err_cnt;
    int err_mark;
    int test_cnt;
    int fail_cnt;
    int seed;

    logic [3:0] got_flags;
    logic [3:0] got_vd;

    assign got_flags = {s1_o.cache_rreq, s1_o.cache_wreq, s1_o.uc_rreq, s1_o.uc_wreq};
    assign got_vd    = {s1_o.valid0, s1_o.valid1, s1_o.dirty0, s1_o.dirty1};

    dcache_s1_top u_dcache_s1_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (req_i),
        .stall_i       (stall_i),
        .s2_fb_i       (s2_fb_i),
        .rend_i        (rend_i),
        .line_rdata_i  (line_rdata_i),
        .s1_o          (s1_o),
        .tag0_o        (tag0_o),
        .tag1_o        (tag1_o),
        .word0_o       (word0_o),
        .word1_o       (word1_o),
        .lru_o         (lru_o),
        .victim_line_o (victim_line_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
        err_cnt++;
    endtask

    //////////////////////////////
    // output checks
    //////////////////////////////

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        chk_flags |-> got_flags == exp_flags)
        else report_mismatch("s1_o flags", 256'($sampled(got_flags)), 256'(exp_flags));
    a_vaddr: assert property (@(posedge clk) disable iff (!rst_n)
        chk_flags |-> s1_o.vaddr == exp_vaddr)
        else report_mismatch("s1_o.vaddr", 256'($sampled(s1_o.vaddr)), 256'(exp_vaddr));
    a_req_fields: assert property (@(posedge clk) disable iff (!rst_n)
        chk_flags |-> {s1_o.paddr, s1_o.cached, s1_o.wen} == {exp_paddr, exp_cached, exp_wen})
        else report_mismatch("s1_o paddr/cached/wen",
                             256'($sampled({s1_o.paddr, s1_o.cached, s1_o.wen})),
                             256'({exp_paddr, exp_cached, exp_wen}));
    a_state: assert property (@(posedge clk) disable iff (!rst_n)
        chk_state |-> got_vd == exp_vd)
        else report_mismatch("s1_o valid/dirty", 256'($sampled(got_vd)), 256'(exp_vd));
    a_tag0: assert property (@(posedge clk) disable iff (!rst_n)
        chk_tag[0] |-> tag0_o == exp_tag0)
        else report_mismatch("tag0_o", 256'($sampled(tag0_o)), 256'(exp_tag0));
    a_tag1: assert property (@(posedge clk) disable iff (!rst_n)
        chk_tag[1] |-> tag1_o == exp_tag1)
        else report_mismatch("tag1_o", 256'($sampled(tag1_o)), 256'(exp_tag1));
    a_word0: assert property (@(posedge clk) disable iff (!rst_n)
        chk_word[0] |-> word0_o == exp_word0)
        else report_mismatch("word0_o", 256'($sampled(word0_o)), 256'(exp_word0));
    a_word1: assert property (@(posedge clk) disable iff (!rst_n)
        chk_word[1] |-> word1_o == exp_word1)
        else report_mismatch("word1_o", 256'($sampled(word1_o)), 256'(exp_word1));
    a_lru: assert property (@(posedge clk) disable iff (!rst_n)
        chk_lru |-> lru_o == exp_lru)
        else report_mismatch("lru_o", 256'($sampled(lru_o)), 256'(exp_lru));
    a_victim: assert property (@(posedge clk) disable iff (!rst_n)
        chk_victim |-> victim_line_o == exp_victim)
        else report_mismatch("victim_line_o", $sampled(victim_line_o), exp_victim);
    a_colli: assert property (@(posedge clk) disable iff (!rst_n)
        chk_colli |-> {s1_o.colli0, s1_o.colli1, s1_o.colli_wdata}
                      == {exp_colli0, exp_colli1, exp_colli_wdata})
        else report_mismatch("s1_o colli",
                             256'($sampled({s1_o.colli0, s1_o.colli1, s1_o.colli_wdata})),
                             256'({exp_colli0, exp_colli1, exp_colli_wdata}));

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic dcache_pkg::line_t rand_line();
        dcache_pkg::line_t l;
        for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
            l[b] = $random(seed);
        end
        return l;
    endfunction

    // old_* fields point at addr so lru_o and the word selects follow it
    task automatic idle_inputs(input logic [31:0] addr);
        req_i             = '0;
        req_i.vaddr       = addr;
        req_i.paddr       = addr;
        s2_fb_i           = '0;
        s2_fb_i.old_vaddr = addr;
        s2_fb_i.old_paddr = addr;
        rend_i            = 1'b0;
    endtask

    task automatic checks_off();
        chk_flags  = 1'b0;
        chk_state  = 1'b0;
        chk_lru    = 1'b0;
        chk_colli  = 1'b0;
        chk_victim = 1'b0;
        chk_tag    = '0;
        chk_word   = '0;
    endtask

    // request fields as driven, paddr follows vaddr
    task automatic expect_req(input logic [3:0] flags, input logic [31:0] addr,
                              input logic cached, input dcache_pkg::byte_en_t wen);
        exp_flags  = flags;
        exp_vaddr  = addr;
        exp_paddr  = addr;
        exp_cached = cached;
        exp_wen    = wen;
        chk_flags  = 1'b1;
    endtask

    task automatic expect_set(input dcache_pkg::index_t idx, input dcache_pkg::bank_t bank);
        logic way;
        way        = sb_lru[idx];
        exp_vd     = {sb_valid[idx][0], sb_valid[idx][1], sb_dirty[idx][0], sb_dirty[idx][1]};
        exp_tag0   = sb_tag[idx][0];
        exp_tag1   = sb_tag[idx][1];
        exp_word0  = sb_line[idx][0][bank];
        exp_word1  = sb_line[idx][1][bank];
        exp_lru    = way;
        exp_victim = sb_line[idx][way];
        chk_state  = 1'b1;
        chk_lru    = 1'b1;
        // invalid ways hold unknown ram contents
        chk_tag    = {sb_valid[idx][1], sb_valid[idx][0]};
        chk_word   = {sb_valid[idx][1], sb_valid[idx][0]};
        chk_victim = sb_valid[idx][way];
    endtask

    // request one cycle, then check s1_o and the ram outputs
    task automatic read_check(input dcache_pkg::tag_t tag, input dcache_pkg::index_t idx,
                              input dcache_pkg::bank_t bank);
        logic [31:0] addr;
        addr = {tag, idx, bank, 2'b00};
        idle_inputs(addr);
        req_i.en     = 1'b1;
        req_i.cached = 1'b1;
        @(negedge clk);
        expect_req(4'b1000, addr, 1'b1, 4'h0);
        exp_colli0      = '0;
        exp_colli1      = '0;
        exp_colli_wdata = '0;
        chk_colli       = 1'b1;
        expect_set(idx, bank);
        req_i.en = 1'b0;
        @(negedge clk);
        checks_off();
    endtask

    task automatic issue_req(input logic cached, input dcache_pkg::byte_en_t wen,
                             input logic [31:0] addr, input logic [3:0] flags);
        idle_inputs(addr);
        req_i.en     = 1'b1;
        req_i.cached = cached;
        req_i.wen    = wen;
        @(negedge clk);
        expect_req(flags, addr, cached, wen);
        idle_inputs(addr);
        @(negedge clk);
        checks_off();
    endtask

    task automatic write_miss(input logic [31:0] addr, input dcache_pkg::byte_en_t wen,
                              input dcache_pkg::word_t data);
        idle_inputs(addr);
        s2_fb_i.write_miss = 1'b1;
        s2_fb_i.old_wen    = wen;
        s2_fb_i.old_data   = data;
        sb_pending         = 1'b1;
        @(negedge clk);
        idle_inputs(addr);
    endtask

    task automatic refill(input dcache_pkg::tag_t tag, input dcache_pkg::index_t idx,
                          input dcache_pkg::bank_t bank, input dcache_pkg::byte_en_t wen,
                          input dcache_pkg::word_t data);
        dcache_pkg::line_t line;
        logic              way;
        logic [31:0]       addr;
        addr = {tag, idx, bank, 2'b00};
        line = rand_line();
        way  = sb_lru[idx];
        idle_inputs(addr);
        s2_fb_i.refilling = 1'b1;
        s2_fb_i.old_wen   = wen;
        s2_fb_i.old_data  = data;
        rend_i            = 1'b1;
        line_rdata_i      = line;
        // store bytes of a pending write miss win over memory
        if (sb_pending) begin
            for (int k = 0; k < 4; k++) begin
                if (wen[k]) begin
                    line[bank][8*k +: 8] = data[8*k +: 8];
                end
            end
        end
        sb_line[idx][way]  = line;
        sb_tag[idx][way]   = tag;
        sb_valid[idx][way] = 1'b1;
        sb_dirty[idx][way] = sb_pending;
        sb_lru[idx]        = ~way;
        sb_pending         = 1'b0;
        @(negedge clk);
        idle_inputs(addr);
    endtask

    task automatic setup_hit_write(input logic [31:0] addr, input logic way,
                                   input dcache_pkg::word_t data);
        idle_inputs(addr);
        s2_fb_i.wreq      = 1'b1;
        s2_fb_i.hit0      = ~way;
        s2_fb_i.hit1      = way;
        s2_fb_i.hit_wdata = data;
        sb_line[addr[10:5]][way][addr[4:2]] = data;
        sb_dirty[addr[10:5]][way] = 1'b1;
        sb_lru[addr[10:5]] = ~way;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark) begin
            fail_cnt++;
            $display("test %0d %s: failed", test_cnt, name);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
        err_mark = err_cnt;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    //////////////////////////////
    // reset and watchdog
    //////////////////////////////

    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end

    initial begin
        for (int i = 0; i < 3000; i++) begin
            @(posedge clk);
        end
        $display("timeout: test sequence did not finish");
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        dcache_pkg::tag_t   tag_a;
        dcache_pkg::tag_t   tag_b;
        dcache_pkg::word_t  wd;
        seed     = 32'h3f33_eb82;
        err_cnt  = 0;
        err_mark = 0;
        test_cnt = 0;
        fail_cnt = 0;
        tag_a    = 21'h1a2b3;
        tag_b    = 21'h0c0de;
        stall_i      = 1'b0;
        line_rdata_i = '0;
        sb_pending   = 1'b0;
        idle_inputs('0);
        checks_off();
        for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
            sb_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                sb_valid[s][w] = 1'b0;
                sb_dirty[s][w] = 1'b0;
                sb_tag[s][w]   = '0;
                sb_line[s][w]  = '0;
            end
        end
        wait_reset_release();
        @(negedge clk);

        // quiet after reset
        expect_req('0, '0, 1'b0, '0);
        exp_vd    = '0;
        exp_lru   = 1'b0;
        chk_state = 1'b1;
        chk_lru   = 1'b1;
        repeat (3) @(negedge clk);
        checks_off();
        end_test("reset state");

        issue_req(1'b1, 4'h0, 32'h0000_1040, 4'b1000);
        issue_req(1'b1, 4'hf, 32'h0000_2044, 4'b0100);
        issue_req(1'b0, 4'h0, 32'h0000_3048, 4'b0010);
        issue_req(1'b0, 4'h3, 32'h0000_404c, 4'b0001);
        // stage register frozen under stall
        idle_inputs(32'h0000_5050);
        req_i.en     = 1'b1;
        req_i.cached = 1'b1;
        @(negedge clk);
        expect_req(4'b1000, 32'h0000_5050, 1'b1, 4'h0);
        stall_i      = 1'b1;
        idle_inputs(32'h0000_6060);
        req_i.en     = 1'b1;
        req_i.wen    = 4'hf;
        repeat (4) @(negedge clk);
        stall_i = 1'b0;
        @(negedge clk);
        expect_req(4'b0001, 32'h0000_6060, 1'b0, 4'hf);
        idle_inputs(32'h0000_6060);
        @(negedge clk);
        checks_off();
        end_test("request kinds and stall");

        refill(tag_a, 6'd5, 3'd3, 4'h0, '0);
        read_check(tag_a, 6'd5, 3'd3);
        end_test("clean refill");

        wd = $random(seed);
        write_miss({tag_b, 6'd5, 3'd6, 2'b00}, 4'b0101, wd);
        refill(tag_b, 6'd5, 3'd6, 4'b0101, wd);
        read_check(tag_b, 6'd5, 3'd6);
        end_test("write miss merge");

        wd = $random(seed);
        setup_hit_write({tag_a, 6'd5, 3'd2, 2'b00}, 1'b0, wd);
        @(negedge clk);
        idle_inputs('0);
        read_check(tag_a, 6'd5, 3'd2);
        read_check(tag_a, 6'd5, 3'd3);
        end_test("hit write");

        // read of the bank being written this cycle
        wd = $random(seed);
        setup_hit_write({tag_b, 6'd5, 3'd6, 2'b00}, 1'b1, wd);
        req_i.en     = 1'b1;
        req_i.cached = 1'b1;
        @(negedge clk);
        expect_req(4'b1000, {tag_b, 6'd5, 3'd6, 2'b00}, 1'b1, 4'h0);
        exp_colli0      = '0;
        exp_colli1      = 8'b1 << 6;
        exp_colli_wdata = wd;
        chk_colli       = 1'b1;
        idle_inputs({tag_b, 6'd5, 3'd6, 2'b00});
        @(negedge clk);
        checks_off();
        read_check(tag_b, 6'd5, 3'd6);
        end_test("read and hit write collision");

        $display("tests %0d, failed tests %0d, failed checks %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
dcache_pkg.sv
dcache_sdp_ram.sv
dcache_line_state.sv
dcache_data_wr_arb.sv
dcache_s1_stage.sv
dcache_s1_top.sv
tb_dcache_s1.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_s1
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
